// File: source/issue_cfg.svh
// ##############################
// Size macros for the issue subsystem
// Tags, register index width, operands, pipeline depth
// ##############################

`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// In-flight tags, also wait slots and table entries
`define ISSUE_NUM_TAGS   8
// Architectural register index width
`define ISSUE_REG_IDX_W  5
// Sources per instruction
`define ISSUE_NUM_OPS    2
// Execution pipeline stages
`define ISSUE_PIPE_DEPTH 3

`endif

// File: source/issue_types_pkg.sv
// ##############################
// Width typedefs and the wait-slot state enum
// ##############################

`include "issue_cfg.svh"

package issue_types_pkg;

    // Tag naming one in-flight instruction
    typedef logic [$clog2(`ISSUE_NUM_TAGS)-1:0] tag_t;

    // Architectural register index
    typedef logic [`ISSUE_REG_IDX_W-1:0] reg_idx_t;

    // Opcode, carried as payload only
    typedef logic [7:0] opc_t;

    // Wait-slot life cycle
    typedef enum logic [1:0] {
        SLOT_FREE  = 2'd0,
        SLOT_WAIT  = 2'd1,
        SLOT_READY = 2'd2
    } slot_state_e;

endpackage

// File: source/issue_bus_pkg.sv
// ##############################
// Packed structs passed between the issue blocks
// ##############################

`include "issue_cfg.svh"

package issue_bus_pkg;

    // Instruction offered by the decoder
    typedef struct packed {
        issue_types_pkg::reg_idx_t                     dst;
        issue_types_pkg::reg_idx_t [`ISSUE_NUM_OPS-1:0] src;
        issue_types_pkg::opc_t                         opc;
    } inst_t;

    // Source lookup result from the register table
    typedef struct packed {
        logic [`ISSUE_NUM_OPS-1:0]                 ready;
        issue_types_pkg::tag_t [`ISSUE_NUM_OPS-1:0] tag;
    } src_info_t;

    // Issue to the execution pipeline
    typedef struct packed {
        issue_types_pkg::tag_t tag;
        issue_types_pkg::opc_t opc;
    } issue_t;

    // Completion broadcast
    typedef struct packed {
        logic                  valid;
        issue_types_pkg::tag_t tag;
        issue_types_pkg::opc_t opc;
    } done_t;

endpackage

// File: source/tag_pool.sv
// ##############################
// Free-tag pool, lowest free tag first
// ##############################

`timescale 1ns/100ps

`include "issue_cfg.svh"

module tag_pool (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // Take the presented tag
    input  logic                  alloc_i,
    // Completion returns a tag
    input  issue_bus_pkg::done_t  done_i,
    output logic                  avail_o,
    output issue_types_pkg::tag_t tag_o
);

    // One bit per tag, set while free
    logic [`ISSUE_NUM_TAGS-1:0] free_q;
    logic [`ISSUE_NUM_TAGS-1:0] free_d;

    // Priority pick, the last write wins so the lowest index is granted
    always_comb begin
        avail_o = |free_q;
        tag_o   = '0;
        for (int i = `ISSUE_NUM_TAGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                tag_o = issue_types_pkg::tag_t'(i);
            end
        end
    end

    // Grant and recycle never hit the same tag
    // A granted tag is free, a completing tag is busy
    always_comb begin
        free_d = free_q;
        if (alloc_i) begin
            free_d[tag_o] = 1'b0;
        end
        if (done_i.valid) begin
            free_d[done_i.tag] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            free_q <= '1;
        end else begin
            free_q <= free_d;
        end
    end

endmodule

// File: source/reg_table.sv
// ##############################
// Register table: latest in-flight producer per register
// Source readiness with same-cycle completion bypass
// ##############################

`timescale 1ns/100ps

`include "issue_cfg.svh"

module reg_table (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Decoder side
    input  logic                     insert_i,
    input  issue_types_pkg::tag_t    tag_i,
    input  issue_bus_pkg::inst_t     inst_i,
    // Completion broadcast
    input  issue_bus_pkg::done_t     done_i,
    output logic                     space_o,
    output issue_bus_pkg::src_info_t src_o
);

    // ##############################
    // Entry storage
    // ##############################

    // Destination and the tag that will write it
    typedef struct packed {
        issue_types_pkg::reg_idx_t dst;
        issue_types_pkg::tag_t     prod;
    } entry_t;

    logic   [`ISSUE_NUM_TAGS-1:0] valid_q;
    logic   [`ISSUE_NUM_TAGS-1:0] valid_d;
    entry_t [`ISSUE_NUM_TAGS-1:0] entry_q;
    entry_t [`ISSUE_NUM_TAGS-1:0] entry_d;

    // Insert target search
    logic                       dst_hit;
    issue_types_pkg::tag_t      dst_hit_idx;
    issue_types_pkg::tag_t      free_idx;
    logic [`ISSUE_NUM_TAGS-1:0] wr_en;
    logic [`ISSUE_NUM_OPS-1:0]  src_hit;

    // Full only when every entry is valid
    assign space_o = ~&valid_q;

    // ##############################
    // Source lookup
    // ##############################

    // At most one valid entry per destination, so any match is the match
    always_comb begin
        src_o   = '0;
        src_hit = '0;
        for (int op = 0; op < `ISSUE_NUM_OPS; op++) begin
            for (int e = `ISSUE_NUM_TAGS - 1; e >= 0; e--) begin
                if (valid_q[e] && entry_q[e].dst == inst_i.src[op]) begin
                    src_hit[op]   = 1'b1;
                    src_o.tag[op] = entry_q[e].prod;
                end
            end
            // Producer finishing right now counts as ready
            src_o.ready[op] = !src_hit[op] ||
                              (done_i.valid && done_i.tag == src_o.tag[op]);
        end
    end

    // ##############################
    // Insert target
    // ##############################

    // Existing entry for the same destination, else lowest free one
    always_comb begin
        dst_hit     = 1'b0;
        dst_hit_idx = '0;
        free_idx    = '0;
        for (int e = `ISSUE_NUM_TAGS - 1; e >= 0; e--) begin
            if (valid_q[e] && entry_q[e].dst == inst_i.dst) begin
                dst_hit     = 1'b1;
                dst_hit_idx = issue_types_pkg::tag_t'(e);
            end
            if (!valid_q[e]) begin
                free_idx = issue_types_pkg::tag_t'(e);
            end
        end
        wr_en = '0;
        if (insert_i) begin
            wr_en[dst_hit ? dst_hit_idx : free_idx] = 1'b1;
        end
    end

    // ##############################
    // Next state
    // ##############################

    // Rewritten entry survives a completion of its old producer
    always_comb begin
        valid_d = valid_q;
        entry_d = entry_q;
        for (int e = 0; e < `ISSUE_NUM_TAGS; e++) begin
            if (wr_en[e]) begin
                valid_d[e]      = 1'b1;
                entry_d[e].dst  = inst_i.dst;
                entry_d[e].prod = tag_i;
            end else if (done_i.valid && valid_q[e] && entry_q[e].prod == done_i.tag) begin
                // Result now architectural
                valid_d[e] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // Entry contents qualified by valid_q
    always_ff @(posedge clk_i) begin
        entry_q <= entry_d;
    end

endmodule

// File: source/wait_buffer.sv
// ##############################
// Wait buffer: one slot per tag, wakeup and issue select
// ##############################

`timescale 1ns/100ps

`include "issue_cfg.svh"

module wait_buffer (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Decoder side, slot picked by tag
    input  logic                     insert_i,
    input  issue_types_pkg::tag_t    tag_i,
    input  issue_bus_pkg::inst_t     inst_i,
    input  issue_bus_pkg::src_info_t src_i,
    // Completion broadcast
    input  issue_bus_pkg::done_t     done_i,
    // To execution pipeline
    output logic                     issue_valid_o,
    output issue_bus_pkg::issue_t    issue_o
);

    // ##############################
    // Slot storage
    // ##############################

    // Payload plus per-operand wait bookkeeping
    typedef struct packed {
        issue_types_pkg::opc_t                     opc;
        logic [`ISSUE_NUM_OPS-1:0]                 waiting;
        issue_types_pkg::tag_t [`ISSUE_NUM_OPS-1:0] prod;
    } slot_t;

    issue_types_pkg::slot_state_e state_q [`ISSUE_NUM_TAGS];
    issue_types_pkg::slot_state_e state_d [`ISSUE_NUM_TAGS];
    slot_t [`ISSUE_NUM_TAGS-1:0]  slot_q;
    slot_t [`ISSUE_NUM_TAGS-1:0]  slot_d;

    // Slot chosen for issue this cycle
    issue_types_pkg::tag_t sel;

    // ##############################
    // Issue select
    // ##############################

    // Lowest ready slot wins
    always_comb begin
        issue_valid_o = 1'b0;
        sel           = '0;
        for (int i = `ISSUE_NUM_TAGS - 1; i >= 0; i--) begin
            if (state_q[i] == issue_types_pkg::SLOT_READY) begin
                issue_valid_o = 1'b1;
                sel           = issue_types_pkg::tag_t'(i);
            end
        end
        // Slot index is the tag
        issue_o.tag = sel;
        issue_o.opc = slot_q[sel].opc;
    end

    // ##############################
    // Slot update
    // ##############################

    always_comb begin
        for (int i = 0; i < `ISSUE_NUM_TAGS; i++) begin
            state_d[i] = state_q[i];
            slot_d[i]  = slot_q[i];
            if (insert_i && tag_i == issue_types_pkg::tag_t'(i)) begin
                // src_i already folds in a same-cycle completion
                slot_d[i].opc     = inst_i.opc;
                slot_d[i].waiting = ~src_i.ready;
                slot_d[i].prod    = src_i.tag;
                state_d[i]        = (&src_i.ready) ? issue_types_pkg::SLOT_READY
                                                   : issue_types_pkg::SLOT_WAIT;
            end else if (issue_valid_o && sel == issue_types_pkg::tag_t'(i)) begin
                // Left for the pipeline, tag stays busy in the pool
                state_d[i] = issue_types_pkg::SLOT_FREE;
            end else if (state_q[i] == issue_types_pkg::SLOT_WAIT && done_i.valid) begin
                // Wakeup on matching producer
                for (int op = 0; op < `ISSUE_NUM_OPS; op++) begin
                    if (slot_q[i].prod[op] == done_i.tag) begin
                        slot_d[i].waiting[op] = 1'b0;
                    end
                end
                if (slot_d[i].waiting == '0) begin
                    state_d[i] = issue_types_pkg::SLOT_READY;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `ISSUE_NUM_TAGS; i++) begin
                state_q[i] <= issue_types_pkg::SLOT_FREE;
            end
        end else begin
            state_q <= state_d;
        end
    end

    // Payload only meaningful while the slot is occupied
    always_ff @(posedge clk_i) begin
        slot_q <= slot_d;
    end

endmodule

// File: source/exec_pipe.sv
// ##############################
// Fixed-latency execution pipeline
// ##############################

`timescale 1ns/100ps

`include "issue_cfg.svh"

module exec_pipe (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // Always accepted, no stall
    input  logic                  issue_valid_i,
    input  issue_bus_pkg::issue_t issue_i,
    // Last stage is the broadcast
    output issue_bus_pkg::done_t  done_o
);

    // Stage valids, stage 0 is the youngest
    logic [`ISSUE_PIPE_DEPTH-1:0] vld_q;

    // Stage payloads
    issue_bus_pkg::issue_t [`ISSUE_PIPE_DEPTH-1:0] stage_q;

    // ##############################
    // Shift
    // ##############################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`ISSUE_PIPE_DEPTH-2:0], issue_valid_i};
        end
    end

    // Payload follows its valid bit
    always_ff @(posedge clk_i) begin
        stage_q[0] <= issue_i;
        for (int s = 1; s < `ISSUE_PIPE_DEPTH; s++) begin
            stage_q[s] <= stage_q[s-1];
        end
    end

    // Completion seen ISSUE_PIPE_DEPTH cycles after issue
    always_comb begin
        done_o.valid = vld_q[`ISSUE_PIPE_DEPTH-1];
        done_o.tag   = stage_q[`ISSUE_PIPE_DEPTH-1].tag;
        done_o.opc   = stage_q[`ISSUE_PIPE_DEPTH-1].opc;
    end

endmodule

// File: source/issue_top.sv
// ##############################
// Issue subsystem top: pool, table, wait buffer, pipeline
// ##############################

`timescale 1ns/100ps

module issue_top (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // Decoder port
    input  logic                  inst_valid_i,
    input  issue_bus_pkg::inst_t  inst_i,
    output logic                  ready_o,
    output issue_types_pkg::tag_t accept_tag_o,
    // Completion port
    output logic                  done_valid_o,
    output issue_types_pkg::tag_t done_tag_o,
    output issue_types_pkg::opc_t done_opc_o
);

    logic                     pool_avail;
    logic                     tbl_space;
    logic                     accept;
    issue_types_pkg::tag_t    new_tag;
    issue_bus_pkg::src_info_t src_info;
    logic                     iss_valid;
    issue_bus_pkg::issue_t    iss;
    issue_bus_pkg::done_t     done;

    // Single accept condition drives every insert
    assign ready_o      = pool_avail && tbl_space;
    assign accept       = inst_valid_i && ready_o;
    assign accept_tag_o = new_tag;

    tag_pool u_pool (
        .clk_i, .arst_n_i, .alloc_i(accept), .done_i(done),
        .avail_o(pool_avail), .tag_o(new_tag)
    );

    reg_table u_table (
        .clk_i, .arst_n_i, .insert_i(accept), .tag_i(new_tag), .inst_i,
        .done_i(done), .space_o(tbl_space), .src_o(src_info)
    );

    wait_buffer u_wbuf (
        .clk_i, .arst_n_i, .insert_i(accept), .tag_i(new_tag), .inst_i,
        .src_i(src_info), .done_i(done), .issue_valid_o(iss_valid), .issue_o(iss)
    );

    exec_pipe u_pipe (
        .clk_i, .arst_n_i, .issue_valid_i(iss_valid), .issue_i(iss), .done_o(done)
    );

    // Completion out
    assign done_valid_o = done.valid;
    assign done_tag_o   = done.tag;
    assign done_opc_o   = done.opc;

endmodule

// File: testbench/issue_asserts.sv
// ##############################
// Concurrent checks on the register table and the tag pool
// Bound into the issue top level
// ##############################

`timescale 1ns/100ps

`include "issue_cfg.svh"

module issue_asserts (
    input logic                                   clk_i,
    input logic                                   arst_n_i,
    // Register table view
    input logic [`ISSUE_NUM_TAGS-1:0]             tbl_valid_i,
    input logic [`ISSUE_NUM_TAGS-1:0]
                [`ISSUE_REG_IDX_W+$clog2(`ISSUE_NUM_TAGS)-1:0] tbl_entry_i,
    // Tag pool view
    input logic                                   pool_alloc_i,
    input issue_types_pkg::tag_t                  pool_tag_i,
    input issue_bus_pkg::done_t                   pool_done_i
);

    localparam int TAG_W   = $clog2(`ISSUE_NUM_TAGS);
    localparam int ENTRY_W = `ISSUE_REG_IDX_W + TAG_W;

    // Two valid entries sharing a destination or a producer
    logic dup;

    // Tags granted and not yet completed, seen at the pool ports
    logic [`ISSUE_NUM_TAGS-1:0] busy_q;

    always_comb begin
        dup = 1'b0;
        for (int a = 0; a < `ISSUE_NUM_TAGS; a++) begin
            for (int b = a + 1; b < `ISSUE_NUM_TAGS; b++) begin
                if (tbl_valid_i[a] && tbl_valid_i[b] &&
                    (tbl_entry_i[a][ENTRY_W-1 -: `ISSUE_REG_IDX_W] ==
                     tbl_entry_i[b][ENTRY_W-1 -: `ISSUE_REG_IDX_W] ||
                     tbl_entry_i[a][TAG_W-1:0] == tbl_entry_i[b][TAG_W-1:0])) begin
                    dup = 1'b1;
                end
            end
        end
    end

    // Set on grant, cleared on completion
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
        end else begin
            if (pool_alloc_i) begin
                busy_q[pool_tag_i] <= 1'b1;
            end
            if (pool_done_i.valid) begin
                busy_q[pool_done_i.tag] <= 1'b0;
            end
        end
    end

    // ##############################
    // Properties
    // ##############################

    unique_entries: assert property (@(posedge clk_i) disable iff (!arst_n_i) !dup)
        else $error("register table holds two valid entries with one destination or producer");

    // Every entry names its own in-flight producer, so a free tag means a free entry
    insert_room: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $countones(tbl_valid_i) <= $countones(busy_q))
        else $error("register table holds more entries than tags in flight");

    grant_free_tag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pool_alloc_i |-> !busy_q[pool_tag_i])
        else $error("tag pool granted a tag that is still busy");

endmodule

// Table and pool both live under the top
bind issue_top issue_asserts u_asserts (
    .clk_i,
    .arst_n_i,
    .tbl_valid_i  (u_table.valid_q),
    .tbl_entry_i  (u_table.entry_q),
    .pool_alloc_i (u_pool.alloc_i),
    .pool_tag_i   (u_pool.tag_o),
    .pool_done_i  (u_pool.done_i)
);

// File: testbench/issue_tb.sv
// ##############################
// Issue subsystem testbench
// LCG stimulus, dependency model, checks, watchdog
// ##############################

`timescale 1ns/100ps

`include "issue_cfg.svh"

module issue_tb;

    localparam int NUM_RANDOM  = 300;
    localparam int NUM_INSTS   = NUM_RANDOM + 3;
    // Worst case per instruction, a full chain of tags ahead of it
    localparam int INST_CYCLES = 40;
    localparam int DRAIN_LIMIT = 100;
    localparam int WATCHDOG_NS = (NUM_INSTS * INST_CYCLES + 20) * 8;

    logic                  clk_i = 1'b0;
    logic                  arst_n_i;
    logic                  inst_valid_i;
    issue_bus_pkg::inst_t  inst_i;
    logic                  ready_o;
    issue_types_pkg::tag_t accept_tag_o;
    logic                  done_valid_o;
    issue_types_pkg::tag_t done_tag_o;
    issue_types_pkg::opc_t done_opc_o;

    issue_top dut0 (.*);

    always #4 clk_i = ~clk_i;

    // ##############################
    // Model state
    // ##############################

    logic [31:0] seed = 32'h90c64cd1;
    string       test_name = "init";
    int          cycle = 0;
    int          err_cnt = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          acc_total = 0;
    int          done_total = 0;
    int          flight_cnt = 0;
    // Per tag
    logic                  in_flight [`ISSUE_NUM_TAGS];
    logic                  lat_check [`ISSUE_NUM_TAGS];
    int                    acc_cycle [`ISSUE_NUM_TAGS];
    issue_types_pkg::opc_t exp_opc [`ISSUE_NUM_TAGS];
    logic                  pend [`ISSUE_NUM_TAGS][`ISSUE_NUM_OPS];
    issue_types_pkg::tag_t need_tag [`ISSUE_NUM_TAGS][`ISSUE_NUM_OPS];
    // Latest uncompleted producer per register
    logic                  reg_busy [2**`ISSUE_REG_IDX_W];
    issue_types_pkg::tag_t reg_prod [2**`ISSUE_REG_IDX_W];
    // Outputs seen at the last rising edge
    logic                  s_ready;
    logic                  s_done_valid;
    issue_types_pkg::tag_t s_done_tag;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Lowest tag the model holds as free, -1 with all in flight
    function automatic int lowest_free_tag();
        for (int i = 0; i < `ISSUE_NUM_TAGS; i++) begin
            if (!in_flight[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic flag_mismatch(string what, int expected, int actual);
        err_cnt++;
        $display("Fail %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    endtask

    task automatic flag_problem(string msg);
        err_cnt++;
        $display("Error %s: %s", test_name, msg);
    endtask

    // Completion against the model, then wakeup and register retire
    task automatic take_done();
        issue_types_pkg::tag_t t;
        t = done_tag_o;
        assert (in_flight[t])
            else flag_problem($sformatf("done for tag %0d which is not in flight", t));
        if (in_flight[t]) begin
            assert (done_opc_o == exp_opc[t])
                else flag_mismatch($sformatf("opcode of tag %0d", t), exp_opc[t], done_opc_o);
            for (int op = 0; op < `ISSUE_NUM_OPS; op++) begin
                assert (!pend[t][op])
                    else flag_problem($sformatf("tag %0d done before its producer tag %0d",
                                                t, need_tag[t][op]));
            end
            if (lat_check[t]) begin
                assert (cycle - acc_cycle[t] == 4)
                    else flag_mismatch("unloaded latency", 4, cycle - acc_cycle[t]);
            end
            in_flight[t] = 1'b0;
            flight_cnt--;
            done_total++;
        end
        for (int i = 0; i < `ISSUE_NUM_TAGS; i++) begin
            for (int op = 0; op < `ISSUE_NUM_OPS; op++) begin
                if (pend[i][op] && need_tag[i][op] == t) begin
                    pend[i][op] = 1'b0;
                end
            end
        end
        for (int r = 0; r < 2**`ISSUE_REG_IDX_W; r++) begin
            if (reg_busy[r] && reg_prod[r] == t) begin
                reg_busy[r] = 1'b0;
            end
        end
    endtask

    // Record producers before the destination is remapped
    task automatic take_accept(issue_bus_pkg::inst_t inst, issue_types_pkg::tag_t t);
        assert (!in_flight[t]) else flag_problem($sformatf("tag %0d granted twice", t));
        for (int op = 0; op < `ISSUE_NUM_OPS; op++) begin
            pend[t][op]     = reg_busy[inst.src[op]];
            need_tag[t][op] = reg_prod[inst.src[op]];
        end
        reg_busy[inst.dst] = 1'b1;
        reg_prod[inst.dst] = t;
        lat_check[t]       = (flight_cnt == 0);
        in_flight[t]       = 1'b1;
        exp_opc[t]         = inst.opc;
        acc_cycle[t]       = cycle;
        flight_cnt++;
        acc_total++;
    endtask

    // One clock: drive on the falling edge, sample on the rising edge
    task automatic step(input logic vld, input issue_bus_pkg::inst_t inst,
                        output logic acc, output issue_types_pkg::tag_t tag);
        int exp_tag;
        @(negedge clk_i);
        inst_valid_i = vld;
        inst_i       = inst;
        @(posedge clk_i);
        cycle++;
        s_ready      = ready_o;
        s_done_valid = done_valid_o;
        s_done_tag   = done_tag_o;
        acc          = vld && ready_o;
        tag          = accept_tag_o;
        // A tag completing now is still busy in the pool this cycle
        exp_tag      = lowest_free_tag();
        // Back-pressure only with every tag in flight
        assert (ready_o == (flight_cnt < `ISSUE_NUM_TAGS))
            else flag_mismatch("ready_o", flight_cnt < `ISSUE_NUM_TAGS, ready_o);
        if (done_valid_o) begin
            take_done();
        end
        if (acc) begin
            assert (int'(tag) == exp_tag)
                else flag_mismatch("accept_tag_o", exp_tag, tag);
            take_accept(inst, tag);
        end
    endtask

    task automatic drain();
        logic                  acc;
        issue_types_pkg::tag_t tag;
        int                    n;
        n = 0;
        while (flight_cnt > 0 && n < DRAIN_LIMIT) begin
            step(1'b0, '0, acc, tag);
            n++;
        end
        assert (flight_cnt == 0)
            else flag_problem($sformatf("%0d instructions never completed", flight_cnt));
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errs = err_cnt;
        tests_run++;
    endtask

    task automatic end_test();
        if (err_cnt == test_errs) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, err_cnt - test_errs);
        end
    endtask

    // ##############################
    // Sequence
    // ##############################

    initial begin
        logic                  acc;
        issue_types_pkg::tag_t tag;
        issue_types_pkg::tag_t prod_tag;
        issue_bus_pkg::inst_t  inst;
        logic [31:0]           r;
        int                    acc_base;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int i = 0; i < `ISSUE_NUM_TAGS; i++) begin
            in_flight[i] = 1'b0;
            lat_check[i] = 1'b0;
            pend[i]      = '{default: 1'b0};
        end
        for (int i = 0; i < 2**`ISSUE_REG_IDX_W; i++) begin
            reg_busy[i] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        begin_test("reset");
        for (int i = 0; i < 4; i++) begin
            step(1'b0, '0, acc, tag);
            assert (s_ready) else flag_mismatch("ready_o after reset", 1, s_ready);
            assert (!s_done_valid) else flag_mismatch("done_valid_o idle", 0, s_done_valid);
        end
        end_test();

        // Single independent instruction, latency checked at its done
        begin_test("latency");
        inst     = '0;
        inst.dst = 5'd1;
        inst.src = {5'd2, 5'd3};
        inst.opc = 8'h5a;
        step(1'b1, inst, acc, tag);
        assert (acc) else flag_problem("independent instruction refused with no tags in flight");
        drain();
        end_test();

        begin_test("bypass");
        inst.dst = 5'd1;
        inst.src = {5'd2, 5'd2};
        inst.opc = 8'h3c;
        step(1'b1, inst, acc, prod_tag);
        assert (acc) else flag_problem("producer refused with no tags in flight");
        repeat (3) step(1'b0, '0, acc, tag);
        // Producer done lands in this acceptance cycle
        inst.dst = 5'd2;
        inst.src = {5'd1, 5'd1};
        inst.opc = 8'hc3;
        step(1'b1, inst, acc, tag);
        assert (acc && s_done_valid && s_done_tag == prod_tag)
            else flag_problem("consumer not accepted in the cycle of its producer's done");
        drain();
        end_test();

        // Registers from a pool of 4, offers about 3 cycles in 4
        begin_test("random");
        acc_base = acc_total;
        while (acc_total < acc_base + NUM_RANDOM) begin
            r           = lcg_next();
            inst.dst    = 5'(r[9:8]);
            inst.src[0] = 5'(r[11:10]);
            inst.src[1] = 5'(r[13:12]);
            inst.opc    = r[23:16];
            step(r[31:30] != 2'b00, inst, acc, tag);
        end
        drain();
        assert (done_total == acc_total)
            else flag_mismatch("completed count", acc_total, done_total);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, sized from the instruction count
    initial begin
        #(WATCHDOG_NS);
        $display("Error %s: watchdog expired with %0d instructions in flight",
                 test_name, flight_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: all.f
+incdir+source
source/issue_types_pkg.sv
source/issue_bus_pkg.sv
source/tag_pool.sv
source/reg_table.sv
source/wait_buffer.sv
source/exec_pipe.sv
source/issue_top.sv
testbench/issue_asserts.sv
testbench/issue_tb.sv

// File: Bender.yml
package:
  name: issue_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/issue_types_pkg.sv
      - source/issue_bus_pkg.sv
      - source/tag_pool.sv
      - source/reg_table.sv
      - source/wait_buffer.sv
      - source/exec_pipe.sv
      - source/issue_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/issue_asserts.sv
      - testbench/issue_tb.sv
